//--- build.f
+incdir+common
common/cordic_pkg.sv
cordic/cordic_stage.sv
cordic/cordic_pipeline.sv
hw/cordic_input_stage.sv
hw/cordic_output_stage.sv
hw/cordic_top.sv
bench/cordic_tb.sv

//--- build.sh
#!/bin/sh
# Compile the CORDIC testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found"
    exit 1
fi

if ! verilator --binary --timing --assert -f build.f --top-module cordic_tb \
        -Mdir obj_dir -o cordic_sim; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/cordic_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- bench/cordic_tb.sv
`default_nettype none
`include "cordic_params.svh"

module cordic_tb;

    localparam int NUM   = 10;                          // table entries
    localparam int N     = `CORDIC_ITERATIONS;
    localparam int LIMIT = 2 * NUM * (N + 2) * 4 + 64;  // two passes over the table

    logic                               clk;
    logic                               rst;
    logic                               in_valid;
    logic signed [`CORDIC_IO_WIDTH-1:0] x_in;
    logic signed [`CORDIC_IO_WIDTH-1:0] y_in;
    logic signed [`CORDIC_IO_WIDTH-1:0] z_in;
    cordic_pkg::coord_mode_e            coord_mode;
    cordic_pkg::op_mode_e               op_mode;
    logic                               out_ready;
    logic                               in_ready;
    logic                               out_valid;
    logic signed [`CORDIC_IO_WIDTH-1:0] x_out;
    logic signed [`CORDIC_IO_WIDTH-1:0] y_out;
    logic signed [`CORDIC_IO_WIDTH-1:0] z_out;

    // stimulus and expected results, Q16.16
    cordic_pkg::coord_mode_e            tab_coord [NUM];
    cordic_pkg::op_mode_e               tab_op    [NUM];
    logic signed [`CORDIC_IO_WIDTH-1:0] tab_x     [NUM];
    logic signed [`CORDIC_IO_WIDTH-1:0] tab_y     [NUM];
    logic signed [`CORDIC_IO_WIDTH-1:0] tab_z     [NUM];
    logic signed [`CORDIC_IO_WIDTH-1:0] exp_x     [NUM];
    logic signed [`CORDIC_IO_WIDTH-1:0] exp_y     [NUM];
    logic signed [`CORDIC_IO_WIDTH-1:0] exp_z     [NUM];
    int                                 tab_tol   [NUM]; // allowed error in LSB

    int          cyc;          // edges since start, also drives the timeout
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          tx_count;     // accepted inputs
    int          rx_count;     // accepted results
    int          phase;        // 1 = full speed, 2 = random back-pressure
    int          cur_idx;      // entry currently offered
    int          first_acc;
    int          first_out;
    int          last_acc;
    int          last_out;
    int          pend_q [$];   // scoreboard, entry index per item in flight
    int          errs_before;
    logic        stalled;
    logic [31:0] lcg_state;
    logic signed [`CORDIC_IO_WIDTH-1:0] held_x;
    logic signed [`CORDIC_IO_WIDTH-1:0] held_y;
    logic signed [`CORDIC_IO_WIDTH-1:0] held_z;

    cordic_top uut (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .x_in(x_in), .y_in(y_in), .z_in(z_in),
        .coord_mode(coord_mode), .op_mode(op_mode), .out_ready(out_ready),
        .in_ready(in_ready), .out_valid(out_valid),
        .x_out(x_out), .y_out(y_out), .z_out(z_out)
    );

    always #4 clk = ~clk; // period 8

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_close(input string what, input int got, input int want, input int tol);
        longint diff;
        diff = longint'(got) - longint'(want);
        if (diff < 0) begin
            diff = -diff;
        end
        checks = checks + 1;
        if (diff > longint'(tol)) begin
            errors = errors + 1;
            $display("Fail %0t: %s is %0d, expected %0d within %0d", $time, what, got, want, tol);
        end
    endtask

    task automatic set_entry(input int i, input cordic_pkg::coord_mode_e c,
                             input cordic_pkg::op_mode_e o, input int x, input int y,
                             input int z, input int ex, input int ey, input int ez,
                             input int tol);
        tab_coord[i] = c;
        tab_op[i]    = o;
        tab_x[i]     = x;
        tab_y[i]     = y;
        tab_z[i]     = z;
        exp_x[i]     = ex;
        exp_y[i]     = ey;
        exp_z[i]     = ez;
        tab_tol[i]   = tol;
    endtask

    task automatic load_table();
        // cos/sin of 0, 0.5, -1.0 and 1.5 rad
        set_entry(0, cordic_pkg::circular, cordic_pkg::rotation, 0, 0, 0, 65536, 0, 0, 8);
        set_entry(1, cordic_pkg::circular, cordic_pkg::rotation, 0, 0, 32768,
                  57513, 31420, 0, 8);
        set_entry(2, cordic_pkg::linear, cordic_pkg::rotation, 98304, 16384, 49152,
                  98304, 90112, 0, 4);                      // 0.25 + 1.5*0.75
        set_entry(3, cordic_pkg::circular, cordic_pkg::rotation, 0, 0, -65536,
                  35409, -55147, 0, 8);
        set_entry(4, cordic_pkg::linear, cordic_pkg::vectoring, 65536, 49152, 16384,
                  65536, 0, 65536, 4);                      // 0.25 + 0.75/1.0
        // residual y grows with the magnitude, hence the wider bound
        set_entry(5, cordic_pkg::circular, cordic_pkg::vectoring, 196608, 262144, 0,
                  327680, 0, 60771, 16);                    // |(3,4)| and atan(4/3)
        set_entry(6, cordic_pkg::circular, cordic_pkg::rotation, 0, 0, 98304,
                  4636, 65372, 0, 8);
        set_entry(7, cordic_pkg::circular, cordic_pkg::vectoring, 65536, -65536, 0,
                  92682, 0, -51472, 8);                     // sqrt 2 and -pi/4
        set_entry(8, cordic_pkg::linear, cordic_pkg::rotation, -65536, 32768, -32768,
                  -65536, 65536, 0, 4);                     // 0.5 + (-1)(-0.5)
        set_entry(9, cordic_pkg::linear, cordic_pkg::vectoring, 65536, -32768, 32768,
                  65536, 0, 0, 4);                          // 0.5 + (-0.5)/1.0
    endtask

    task automatic send_entry(input int i);
        @(negedge clk);
        cur_idx    = i;
        in_valid   = 1'b1;
        x_in       = tab_x[i];
        y_in       = tab_y[i];
        z_in       = tab_z[i];
        coord_mode = tab_coord[i];
        op_mode    = tab_op[i];
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk); // held until the pipe moves
        end
    endtask

    task automatic run_table();
        for (int i = 0; i < NUM; i++) begin
            send_entry(i);
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (rx_count < tx_count) begin
            @(negedge clk); // watchdog ends the run if this never settles
        end
    endtask

    task automatic report_test(input string name);
        tests_run = tests_run + 1;
        if (errors == errs_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
        errs_before = errors;
    endtask

    // sink readiness, low about one cycle in three under back-pressure
    always @(negedge clk) begin
        lcg_state = lcg_next(lcg_state);
        out_ready = (phase == 2) ? ((lcg_state[23:16] % 8'd3) != 8'd0) : 1'b1;
    end

    // handshakes are taken from the values held just before each edge
    always @(posedge clk) begin : monitor
        int idx;
        cyc = cyc + 1;
        if (!rst) begin
            if (stalled) begin
                check_close("out_valid while stalled", int'(out_valid), 1, 0);
                check_close("x_out while stalled", x_out, held_x, 0);
                check_close("y_out while stalled", y_out, held_y, 0);
                check_close("z_out while stalled", z_out, held_z, 0);
            end
            stalled = out_valid && !out_ready;
            held_x  = x_out;
            held_y  = y_out;
            held_z  = z_out;
            if (in_valid && in_ready) begin
                pend_q.push_back(cur_idx);
                if (phase == 1 && first_acc >= 0) begin
                    check_close("edges between accepts", cyc - last_acc, 1, 0);
                end else if (phase == 1) begin
                    first_acc = cyc;
                end
                last_acc = cyc;
                tx_count = tx_count + 1;
            end
            if (out_valid && out_ready) begin
                if (pend_q.size() == 0) begin
                    errors = errors + 1;
                    $display("a result arrived at %0t with no entry in flight", $time);
                end else begin
                    idx = pend_q.pop_front();
                    check_close($sformatf("entry %0d x_out", idx), x_out, exp_x[idx], tab_tol[idx]);
                    check_close($sformatf("entry %0d y_out", idx), y_out, exp_y[idx], tab_tol[idx]);
                    check_close($sformatf("entry %0d z_out", idx), z_out, exp_z[idx], tab_tol[idx]);
                end
                if (phase == 1 && first_out >= 0) begin
                    check_close("edges between results", cyc - last_out, 1, 0);
                end else if (phase == 1) begin
                    first_out = cyc;
                end
                last_out = cyc;
                rx_count = rx_count + 1;
            end
        end
        if (cyc >= LIMIT) begin
            $display("timeout after %0d cycles, results never arrived", cyc);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        x_in         = '0;
        y_in         = '0;
        z_in         = '0;
        coord_mode   = cordic_pkg::linear;
        op_mode      = cordic_pkg::rotation;
        out_ready    = 1'b1;
        cyc          = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        tx_count     = 0;
        rx_count     = 0;
        phase        = 0;
        cur_idx      = 0;
        first_acc    = -1;
        first_out    = -1;
        last_acc     = 0;
        last_out     = 0;
        errs_before  = 0;
        stalled      = 1'b0;
        lcg_state    = 32'd61;
        load_table();

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        check_close("out_valid after reset", int'(out_valid), 0, 0);
        check_close("in_ready after reset", int'(in_ready), 1, 0);
        report_test("reset");

        @(negedge clk);
        phase <= 1; // takes effect after the sink driver has run on this edge
        run_table();
        check_close("first result latency", first_out - first_acc, N + 2, 0);
        check_close("results at full speed", rx_count, NUM, 0);
        report_test("latency and throughput");

        @(negedge clk);
        phase <= 2;
        run_table();
        check_close("entries left in flight", pend_q.size(), 0, 0);
        check_close("results in total", rx_count, 2 * NUM, 0);
        report_test("back-pressure");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/cordic_top.sv
`default_nettype none
`include "cordic_params.svh"

module cordic_top (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               in_valid,
    input  wire logic signed [`CORDIC_IO_WIDTH-1:0] x_in,
    input  wire logic signed [`CORDIC_IO_WIDTH-1:0] y_in,
    input  wire logic signed [`CORDIC_IO_WIDTH-1:0] z_in,
    input  wire cordic_pkg::coord_mode_e            coord_mode,
    input  wire cordic_pkg::op_mode_e               op_mode,
    input  wire logic                               out_ready,
    output logic                                    in_ready,
    output logic                                    out_valid,
    output logic signed [`CORDIC_IO_WIDTH-1:0]      x_out,
    output logic signed [`CORDIC_IO_WIDTH-1:0]      y_out,
    output logic signed [`CORDIC_IO_WIDTH-1:0]      z_out
);

    logic                                advance;
    logic                                h_valid; // input register to pipeline
    logic signed [`CORDIC_WIDTH-1:0]     h_x, h_y, h_z;
    cordic_pkg::coord_mode_e             h_coord;
    cordic_pkg::op_mode_e                h_op;
    logic                                t_valid; // pipeline to output register
    logic signed [`CORDIC_WIDTH-1:0]     t_x, t_y, t_z;
    cordic_pkg::coord_mode_e             t_coord;
    cordic_pkg::op_mode_e                t_op;

    assign in_ready = advance; // accept whenever the whole pipe moves

    cordic_input_stage u_in (
        .clk(clk), .rst(rst), .advance(advance),
        .in_valid(in_valid), .x_in(x_in), .y_in(y_in), .z_in(z_in),
        .coord_mode(coord_mode), .op_mode(op_mode),
        .s_valid(h_valid), .s_x(h_x), .s_y(h_y), .s_z(h_z),
        .s_coord(h_coord), .s_op(h_op)
    );

    cordic_pipeline u_pipe (
        .clk(clk), .rst(rst), .advance(advance),
        .s_valid(h_valid), .s_x(h_x), .s_y(h_y), .s_z(h_z), .s_coord(h_coord), .s_op(h_op),
        .n_valid(t_valid), .n_x(t_x), .n_y(t_y), .n_z(t_z), .n_coord(t_coord), .n_op(t_op)
    );

    cordic_output_stage u_out (
        .clk(clk), .rst(rst), .out_ready(out_ready),
        .s_valid(t_valid), .s_x(t_x), .s_y(t_y), .s_z(t_z), .s_coord(t_coord), .s_op(t_op),
        .advance(advance), .out_valid(out_valid),
        .x_out(x_out), .y_out(y_out), .z_out(z_out)
    );

endmodule

`default_nettype wire

//--- hw/cordic_output_stage.sv
`default_nettype none
`include "cordic_params.svh"

module cordic_output_stage (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            out_ready,
    input  wire logic                            s_valid, // pipeline tail
    input  wire logic signed [`CORDIC_WIDTH-1:0] s_x,
    input  wire logic signed [`CORDIC_WIDTH-1:0] s_y,
    input  wire logic signed [`CORDIC_WIDTH-1:0] s_z,
    input  wire cordic_pkg::coord_mode_e         s_coord,
    input  wire cordic_pkg::op_mode_e            s_op,
    output logic                                 advance, // global enable for every register
    output logic                                 out_valid,
    output logic signed [`CORDIC_IO_WIDTH-1:0]   x_out,   // Q16.16
    output logic signed [`CORDIC_IO_WIDTH-1:0]   y_out,
    output logic signed [`CORDIC_IO_WIDTH-1:0]   z_out
);

    localparam int W = `CORDIC_WIDTH;

    logic signed [W-1:0]   x_abs;
    logic signed [2*W-1:0] prod;  // |x| * K^-1, Q32.64
    logic signed [W-1:0]   x_fix;

    // move on when the output slot is free or being taken
    assign advance = !out_valid || out_ready;

    assign x_abs = s_x[W-1] ? -s_x : s_x;
    assign prod  = x_abs * `CORDIC_K_INV;

    // vectoring leaves x scaled by K, take the gain back out
    assign x_fix = (s_coord == cordic_pkg::circular && s_op == cordic_pkg::vectoring) ?
                   prod[`CORDIC_FRAC_BITS +: W] : s_x;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            x_out <= x_fix[W-1:`CORDIC_WIDEN_BITS]; // drop the extra fraction bits
            y_out <= s_y[W-1:`CORDIC_WIDEN_BITS];
            z_out <= s_z[W-1:`CORDIC_WIDEN_BITS];
        end
    end

    // circular vectoring only converges for x > 0, so x must still be positive here
    a_vec_x_positive: assert property (@(posedge clk) disable iff (rst)
        (s_valid && s_coord == cordic_pkg::circular && s_op == cordic_pkg::vectoring)
            |-> !s_x[W-1])
        else $error("circular vectoring item left the pipe with negative x");

endmodule

`default_nettype wire

//--- hw/cordic_input_stage.sv
`default_nettype none
`include "cordic_params.svh"

module cordic_input_stage (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                advance,     // global stall release
    input  wire logic                                in_valid,
    input  wire logic signed [`CORDIC_IO_WIDTH-1:0]  x_in,        // Q16.16
    input  wire logic signed [`CORDIC_IO_WIDTH-1:0]  y_in,
    input  wire logic signed [`CORDIC_IO_WIDTH-1:0]  z_in,
    input  wire cordic_pkg::coord_mode_e             coord_mode,
    input  wire cordic_pkg::op_mode_e                op_mode,
    output logic                                     s_valid,
    output logic signed [`CORDIC_WIDTH-1:0]          s_x,         // Q16.32
    output logic signed [`CORDIC_WIDTH-1:0]          s_y,
    output logic signed [`CORDIC_WIDTH-1:0]          s_z,
    output cordic_pkg::coord_mode_e                  s_coord,
    output cordic_pkg::op_mode_e                     s_op
);

    logic circ_rot; // cos/sin request

    assign circ_rot = (coord_mode == cordic_pkg::circular) &&
                      (op_mode == cordic_pkg::rotation);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_valid <= 1'b0;
        end else if (advance) begin
            s_valid <= in_valid; // empty slot enters as a bubble
        end
    end

    // operands and modes, held while stalled
    always_ff @(posedge clk) begin
        if (advance) begin
            s_x     <= circ_rot ? `CORDIC_K_INV
                                : {x_in, {`CORDIC_WIDEN_BITS{1'b0}}}; // preload gain
            s_y     <= circ_rot ? '0
                                : {y_in, {`CORDIC_WIDEN_BITS{1'b0}}};
            s_z     <= {z_in, {`CORDIC_WIDEN_BITS{1'b0}}}; // angle or multiplier
            s_coord <= coord_mode;
            s_op    <= op_mode;
        end
    end

endmodule

`default_nettype wire

//--- cordic/cordic_pipeline.sv
`default_nettype none
`include "cordic_params.svh"

module cordic_pipeline (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        advance,
    input  wire logic                        s_valid, // head of the chain
    input  wire logic signed [`CORDIC_WIDTH-1:0] s_x,
    input  wire logic signed [`CORDIC_WIDTH-1:0] s_y,
    input  wire logic signed [`CORDIC_WIDTH-1:0] s_z,
    input  wire cordic_pkg::coord_mode_e     s_coord,
    input  wire cordic_pkg::op_mode_e        s_op,
    output logic                             n_valid, // tail of the chain
    output logic signed [`CORDIC_WIDTH-1:0]  n_x,
    output logic signed [`CORDIC_WIDTH-1:0]  n_y,
    output logic signed [`CORDIC_WIDTH-1:0]  n_z,
    output cordic_pkg::coord_mode_e          n_coord,
    output cordic_pkg::op_mode_e             n_op
);

    localparam int N = `CORDIC_ITERATIONS;
    localparam int W = `CORDIC_WIDTH;

    // slot k feeds stage k, slot N is the tail
    logic                    v_c [0:N];
    logic signed [W-1:0]     x_c [0:N];
    logic signed [W-1:0]     y_c [0:N];
    logic signed [W-1:0]     z_c [0:N];
    cordic_pkg::coord_mode_e c_c [0:N];
    cordic_pkg::op_mode_e    o_c [0:N];

    assign v_c[0] = s_valid;
    assign x_c[0] = s_x;
    assign y_c[0] = s_y;
    assign z_c[0] = s_z;
    assign c_c[0] = s_coord;
    assign o_c[0] = s_op;

    for (genvar i = 0; i < N; i++) begin : g_stage
        cordic_stage #(
            .STAGE_INDEX(i)
        ) u_stage (
            .clk(clk), .rst(rst), .advance(advance),
            .s_valid(v_c[i]), .s_x(x_c[i]), .s_y(y_c[i]), .s_z(z_c[i]),
            .s_coord(c_c[i]), .s_op(o_c[i]),
            .n_valid(v_c[i+1]), .n_x(x_c[i+1]), .n_y(y_c[i+1]), .n_z(z_c[i+1]),
            .n_coord(c_c[i+1]), .n_op(o_c[i+1])
        );
    end

    assign n_valid = v_c[N];
    assign n_x     = x_c[N];
    assign n_y     = y_c[N];
    assign n_z     = z_c[N];
    assign n_coord = c_c[N];
    assign n_op    = o_c[N];

endmodule

`default_nettype wire

//--- cordic/cordic_stage.sv
`default_nettype none
`include "cordic_params.svh"

module cordic_stage #(
    parameter int STAGE_INDEX = 0 // shift amount and angle table index
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        advance,
    input  wire logic                        s_valid,
    input  wire logic signed [`CORDIC_WIDTH-1:0] s_x,
    input  wire logic signed [`CORDIC_WIDTH-1:0] s_y,
    input  wire logic signed [`CORDIC_WIDTH-1:0] s_z,
    input  wire cordic_pkg::coord_mode_e     s_coord,
    input  wire cordic_pkg::op_mode_e        s_op,
    output logic                             n_valid,
    output logic signed [`CORDIC_WIDTH-1:0]  n_x,
    output logic signed [`CORDIC_WIDTH-1:0]  n_y,
    output logic signed [`CORDIC_WIDTH-1:0]  n_z,
    output cordic_pkg::coord_mode_e          n_coord,
    output cordic_pkg::op_mode_e             n_op
);

    localparam int W = `CORDIC_WIDTH;

    logic signed [W-1:0] x_sh;      // x * 2^-i
    logic signed [W-1:0] y_sh;      // y * 2^-i
    logic signed [W-1:0] alpha;     // angle for this stage
    logic                sigma_pos; // 1 for +1, 0 for -1
    logic signed [W-1:0] x_d;
    logic signed [W-1:0] y_d;
    logic signed [W-1:0] z_d;

    assign x_sh  = s_x >>> STAGE_INDEX;
    assign y_sh  = s_y >>> STAGE_INDEX;
    assign alpha = cordic_pkg::angle_step(s_coord, STAGE_INDEX);

    always_comb begin
        if (s_op == cordic_pkg::rotation) begin
            sigma_pos = ~s_z[W-1];             // rotate toward z = 0
        end else begin
            sigma_pos = (s_x[W-1] != s_y[W-1]); // rotate toward y = 0
        end
    end

    always_comb begin
        y_d = sigma_pos ? (s_y + x_sh) : (s_y - x_sh);
        z_d = sigma_pos ? (s_z - alpha) : (s_z + alpha);
        if (s_coord == cordic_pkg::circular) begin
            x_d = sigma_pos ? (s_x - y_sh) : (s_x + y_sh);
        end else begin
            x_d = s_x; // linear leaves x alone
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            n_valid <= 1'b0;
        end else if (advance) begin
            n_valid <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            n_x     <= x_d;
            n_y     <= y_d;
            n_z     <= z_d;
            n_coord <= s_coord; // modes ride along with the data
            n_op    <= s_op;
        end
    end

    // the previous stage must hand over defined modes with every item
    a_modes_known: assert property (@(posedge clk) disable iff (rst)
        s_valid |-> !$isunknown({s_coord, s_op}))
        else $error("mode bits unknown on a valid item at stage %0d", STAGE_INDEX);

endmodule

`default_nettype wire

//--- common/cordic_pkg.sv
`default_nettype none
`include "cordic_params.svh"

package cordic_pkg;

    typedef enum logic {
        linear   = 1'b0, // y accumulates x*z or z accumulates y/x
        circular = 1'b1  // true rotation in the plane
    } coord_mode_e;

    typedef enum logic {
        rotation  = 1'b0, // drive z toward zero
        vectoring = 1'b1  // drive y toward zero
    } op_mode_e;

    // per-stage angle, Q16.32
    function automatic logic signed [`CORDIC_WIDTH-1:0] angle_step(
        input coord_mode_e coord,
        input int unsigned idx
    );
        logic signed [`CORDIC_WIDTH-1:0] pow2;
        pow2 = (idx <= `CORDIC_FRAC_BITS) ?
               (`CORDIC_WIDTH'sd1 <<< (`CORDIC_FRAC_BITS - idx)) : '0; // 2^-idx
        if (coord == linear) begin
            return pow2;
        end
        case (idx) // atan(2^-idx), only the first entries differ from 2^-idx
            0:       return 48'sd3373259426;
            1:       return 48'sd1991351318;
            2:       return 48'sd1052175346;
            3:       return 48'sd534100635;
            4:       return 48'sd268086748;
            5:       return 48'sd134174063;
            6:       return 48'sd67103403;
            7:       return 48'sd33553749;
            8:       return 48'sd16777131;
            9:       return 48'sd8388597;
            10:      return 48'sd4194303;
            default: return pow2; // atan(x) rounds to x from here on
        endcase
    endfunction

endpackage

`default_nettype wire

//--- common/cordic_params.svh
`ifndef CORDIC_PARAMS_SVH
`define CORDIC_PARAMS_SVH

// port data width, Q16.16
`define CORDIC_IO_WIDTH 32

// internal datapath width, Q16.32
`define CORDIC_WIDTH 48

// fraction bits of the internal format
`define CORDIC_FRAC_BITS 32

// shift from port format up to internal format
`define CORDIC_WIDEN_BITS 16

// number of micro-rotation stages, up to 32 supported by the angle table
`define CORDIC_ITERATIONS 16

// circular gain reciprocal 0.6072529350 in Q16.32
`define CORDIC_K_INV 48'sd2608131496

`endif
